//--- rtl/greet_pkg.sv
// ========================================
// shared constants and stage structs for the
// greeting display, imported by every stage
// ========================================
`default_nettype none

package greet_pkg;
    // display geometry, 640x480 at 800x525 total
    localparam int CORDW        = 10;
    localparam int H_RES        = 640;
    localparam int V_RES        = 480;
    localparam int H_TOTAL      = 800;
    localparam int V_TOTAL      = 525;
    localparam int H_SYNC_START = 656;
    localparam int H_SYNC_END   = 751;
    localparam int V_SYNC_START = 490;
    localparam int V_SYNC_END   = 491;

    // text layout
    localparam int SLOTS      = 8;   // characters per text row
    localparam int SLOT_X0    = 64;
    localparam int SLOT_PITCH = 64;
    localparam int SCALE      = 8;   // same in x and y
    localparam int ROW_Y0     = 150;
    localparam int ROW_Y1     = 250;

    // roms and message timing
    localparam int GLYPH_H    = 8;
    localparam int GLYPHS     = 8;
    localparam int FONT_W     = 8;   // pixels per glyph row
    localparam int GREET_MSGS = 2;
    localparam int GREET_LEN  = 16;
    localparam int MSG_FRAMES = 2;
    localparam GREET_FILE     = "rtl/greet.mem";
    localparam FONT_FILE      = "rtl/font.mem";

    localparam int SLOT_W   = $clog2(SLOTS);
    localparam int GIDX_W   = $clog2(GLYPHS);
    localparam int GROW_W   = $clog2(GLYPH_H);
    localparam int GREET_AW = $clog2(GREET_MSGS * GREET_LEN);
    localparam int FONT_AW  = $clog2(GLYPHS * GLYPH_H);
    localparam int MSG_W    = $clog2(GREET_MSGS);
    localparam int FRM_W    = $clog2(MSG_FRAMES);

    // colour stripes, 4 bits per channel
    localparam logic [11:0] COLR_A    = 12'h125;
    localparam logic [11:0] COLR_B    = 12'h421;
    localparam logic [11:0] COLR_STEP = 12'h111;
    localparam int STRIPE_A0    = 150;
    localparam int STRIPE_B0    = 178;
    localparam int STRIPE_A1    = 250;
    localparam int STRIPE_B1    = 278;
    localparam int STRIPE_LINES = 3;
    localparam int STRIPE_CW    = $clog2(STRIPE_LINES);

    typedef struct packed {
        logic [CORDW-1:0] sx;
        logic [CORDW-1:0] sy;
        logic             hsync;  // active low
        logic             vsync;  // active low
        logic             de;
    } scan_t;

    typedef struct packed {
        logic              valid;
        logic [SLOT_W-1:0] slot;
        logic [GIDX_W-1:0] glyph;
        logic [GROW_W-1:0] row;
        logic              blank;  // no text on this line
    } char_req_t;

    typedef struct packed {
        logic              valid;
        logic [SLOT_W-1:0] slot;
        logic [FONT_W-1:0] bits;  // bit 7 is leftmost
    } glyph_row_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } video_t;
endpackage

`default_nettype wire

//--- rtl/display_timing.sv
// ========================================
// 640x480 display timing, drives the scan
// position and syncs into the pipeline
// ========================================
`timescale 1ns/1ps
`default_nettype none

module display_timing import greet_pkg::*; (
    input  wire logic clk_pix,
    input  wire logic rst_n,
    output scan_t     scan
);

    logic [CORDW-1:0] sx;
    logic [CORDW-1:0] sy;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == CORDW'(H_TOTAL - 1)) begin  // end of line
            sx <= '0;
            sy <= (sy == CORDW'(V_TOTAL - 1)) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // syncs and enable straight from the counters
    always_comb begin
        scan.sx    = sx;
        scan.sy    = sy;
        scan.hsync = ~(sx >= CORDW'(H_SYNC_START) && sx <= CORDW'(H_SYNC_END));
        scan.vsync = ~(sy >= CORDW'(V_SYNC_START) && sy <= CORDW'(V_SYNC_END));
        scan.de    = (sx < CORDW'(H_RES)) && (sy < CORDW'(V_RES));
    end

endmodule

`default_nettype wire

//--- rtl/text_fetch.sv
// ========================================
// picks the greeting and reads its glyph
// indices in hblank, one request per slot
// ========================================
`timescale 1ns/1ps
`default_nettype none

module text_fetch import greet_pkg::*; (
    input  wire logic  clk_pix,
    input  wire logic  rst_n,
    input  wire scan_t scan,
    output char_req_t  req
);

    logic [GIDX_W-1:0]   msg_rom [GREET_MSGS * GREET_LEN];
    logic [FRM_W-1:0]    frm_cnt;
    logic [MSG_W-1:0]    msg;
    logic [CORDW-1:0]    nline;  // line being prepared
    logic [CORDW-1:0]    rel;
    logic                in_r0;
    logic                in_r1;
    logic                fetch;
    logic [SLOT_W-1:0]   fslot;
    logic [GREET_AW-1:0] addr;

    initial $readmemh(GREET_FILE, msg_rom);

    // message selector, steps at start of vblank
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            frm_cnt <= '0;
            msg     <= '0;
        end else if (scan.sx == '0 && scan.sy == CORDW'(V_RES)) begin
            if (frm_cnt == FRM_W'(MSG_FRAMES - 1)) begin
                frm_cnt <= '0;
                msg     <= (msg == MSG_W'(GREET_MSGS - 1)) ? '0 : msg + 1'b1;
            end else begin
                frm_cnt <= frm_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        nline = (scan.sy == CORDW'(V_TOTAL - 1)) ? '0 : scan.sy + 1'b1;
        in_r0 = nline >= CORDW'(ROW_Y0) && nline < CORDW'(ROW_Y0 + GLYPH_H * SCALE);
        in_r1 = nline >= CORDW'(ROW_Y1) && nline < CORDW'(ROW_Y1 + GLYPH_H * SCALE);
        rel   = in_r1 ? nline - CORDW'(ROW_Y1) : nline - CORDW'(ROW_Y0);
        fetch = scan.sx >= CORDW'(H_RES) && scan.sx < CORDW'(H_RES + SLOTS);
        fslot = SLOT_W'(scan.sx - CORDW'(H_RES));
        addr  = GREET_AW'(msg) * GREET_AW'(GREET_LEN) + GREET_AW'(fslot)
              + (in_r1 ? GREET_AW'(SLOTS) : '0);  // second half for row 1
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) req.valid <= 1'b0;
        else        req.valid <= fetch;
    end

    // rom read and request payload
    always_ff @(posedge clk_pix) begin
        req.glyph <= msg_rom[addr];
        req.slot  <= fslot;
        req.row   <= GROW_W'(rel / CORDW'(SCALE));
        req.blank <= ~(in_r0 | in_r1);
    end

endmodule

`default_nettype wire

//--- rtl/glyph_fetch.sv
// ========================================
// font rom reader, turns character requests
// into glyph row bits one cycle later
// ========================================
`timescale 1ns/1ps
`default_nettype none

module glyph_fetch import greet_pkg::*; (
    input  wire logic      clk_pix,
    input  wire logic      rst_n,
    input  wire char_req_t req,
    output glyph_row_t     row
);

    logic [FONT_W-1:0]  font_rom [GLYPHS * GLYPH_H];
    logic [FONT_AW-1:0] addr;

    initial $readmemh(FONT_FILE, font_rom);

    // eight rows per glyph
    always_comb begin
        addr = FONT_AW'(req.glyph) * FONT_AW'(GLYPH_H) + FONT_AW'(req.row);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) row.valid <= 1'b0;
        else        row.valid <= req.valid;
    end

    // slot rides along with the read
    always_ff @(posedge clk_pix) begin
        row.slot <= req.slot;
        if (req.blank) begin
            row.bits <= '0;  // nothing drawn on this line
        end else begin
            row.bits <= font_rom[addr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/glyph_draw.sv
// ========================================
// holds a line of glyph rows and scales them
// 8x across into one pixel-on bit
// ========================================
`timescale 1ns/1ps
`default_nettype none

module glyph_draw import greet_pkg::*; (
    input  wire logic       clk_pix,
    input  wire logic       rst_n,
    input  wire scan_t      scan,
    input  wire glyph_row_t row,
    output scan_t           scan_d,
    output logic            pix_on
);

    logic [FONT_W-1:0] pend [SLOTS];  // filled during hblank
    logic [FONT_W-1:0] disp [SLOTS];  // shown on the current line
    logic [CORDW-1:0]  offs;
    logic [SLOT_W-1:0] slot;
    logic [2:0]        col;
    logic              in_band;

    always_ff @(posedge clk_pix) begin
        if (row.valid) pend[row.slot] <= row.bits;
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n)              disp <= '{default: '0};
        else if (scan.sx == '0) disp <= pend;  // swap at line start
    end

    always_comb begin
        offs    = scan.sx - CORDW'(SLOT_X0);
        slot    = SLOT_W'(offs / CORDW'(SLOT_PITCH));
        col     = 3'((offs % CORDW'(SLOT_PITCH)) / CORDW'(SCALE));
        in_band = scan.sx >= CORDW'(SLOT_X0)
               && scan.sx < CORDW'(SLOT_X0 + SLOTS * SLOT_PITCH);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            scan_d <= '{sx: '0, sy: '0, hsync: 1'b1, vsync: 1'b1, de: 1'b0};
            pix_on <= 1'b0;
        end else begin
            scan_d <= scan;
            pix_on <= in_band && disp[slot][3'(FONT_W - 1) - col];  // msb leftmost
        end
    end

endmodule

`default_nettype wire

//--- rtl/colour_mix.sv
// ========================================
// stepped stripe colour for lit pixels and
// the registered video output
// ========================================
`timescale 1ns/1ps
`default_nettype none

module colour_mix import greet_pkg::*; (
    input  wire logic  clk_pix,
    input  wire logic  rst_n,
    input  wire scan_t scan_d,
    input  wire logic  pix_on,
    output video_t     vid
);

    logic [11:0]          colr;
    logic [STRIPE_CW-1:0] cnt_line;
    logic                 load_a;
    logic                 load_b;

    always_comb begin
        load_a = scan_d.sy == CORDW'(STRIPE_A0) || scan_d.sy == CORDW'(STRIPE_A1);
        load_b = scan_d.sy == CORDW'(STRIPE_B0) || scan_d.sy == CORDW'(STRIPE_B1);
    end

    // colour steps once per STRIPE_LINES lines
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            colr     <= COLR_A;
            cnt_line <= '0;
        end else if (scan_d.sx == '0) begin
            if (load_a || load_b) begin
                colr     <= load_a ? COLR_A : COLR_B;
                cnt_line <= '0;
            end else if (cnt_line == STRIPE_CW'(STRIPE_LINES - 1)) begin
                colr     <= colr + COLR_STEP;  // wraps at 12 bits
                cnt_line <= '0;
            end else begin
                cnt_line <= cnt_line + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            vid <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, r: '0, g: '0, b: '0};
        end else begin
            vid.hsync <= scan_d.hsync;
            vid.vsync <= scan_d.vsync;
            vid.de    <= scan_d.de;
            {vid.r, vid.g, vid.b} <= (scan_d.de && pix_on) ? colr : 12'h000;
        end
    end

endmodule

`default_nettype wire

//--- rtl/greet_top.sv
// ========================================
// greeting display top, runs on clk_pix
// and drives 12-bit video out
// ========================================
`timescale 1ns/1ps
`default_nettype none

module greet_top import greet_pkg::*; (
    input  wire logic clk_pix,
    input  wire logic rst_n,
    output video_t    vid
);

    scan_t      scan;
    scan_t      scan_d;  // one cycle behind scan
    char_req_t  req;
    glyph_row_t row;
    logic       pix_on;

    display_timing u_timing (.clk_pix, .rst_n, .scan);

    text_fetch u_text (.clk_pix, .rst_n, .scan, .req);

    glyph_fetch u_glyph (.clk_pix, .rst_n, .req, .row);

    glyph_draw u_draw (.clk_pix, .rst_n, .scan, .row, .scan_d, .pix_on);

    colour_mix u_colour (.clk_pix, .rst_n, .scan_d, .pix_on, .vid);

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
// ========================================
// free-running pixel clock for the testbench
// ========================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam time HALF_PERIOD = 5;  // 10 ns period

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tb/greet_tb.sv
// ========================================
// greeting display testbench that checks timing,
// text pixels and stripe colours over 5 frames
// ========================================
`timescale 1ns/1ps
`default_nettype none

module greet_tb import greet_pkg::*; ();

    localparam int RUN_FRAMES = 5;
    localparam int RUN_LIMIT  = (RUN_FRAMES + 1) * H_TOTAL * V_TOTAL;

    logic        clk_pix;
    logic        rst_n;
    video_t      vid;
    logic [7:0]  ref_msg  [GREET_MSGS * GREET_LEN];
    logic [7:0]  ref_font [GLYPHS * GLYPH_H];
    logic [11:0] rgb;
    logic        prev_hs;
    logic        prev_vs;
    logic        prev_de;
    logic        seen_rise;
    int          err_cnt;
    int          cyc;
    int          x;
    int          y;
    int          frm;
    int          hs_fall_at;
    int          hs_low;
    int          since_rise;
    int          vs_low;
    int          de_rise_at;

    tb_clock u_clock (.clk(clk_pix));

    greet_top uut (.clk_pix, .rst_n, .vid);

    task automatic end_run();
        if (err_cnt == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "run stopped after a failed check");
        end
    endtask

    task automatic report_count(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("ERR %s expected %0d actual %0d", name, exp, act);
        err_cnt++;
        end_run();
    endtask

    task automatic report_word(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("ERR %s expected 0x%0h actual 0x%0h", name, exp, act);
        err_cnt++;
        end_run();
    endtask

    // lit bit from the message and font tables
    function automatic logic model_lit(input int f, input int ly, input int px);
        int msg;
        int trow;
        int grow;
        int slot;
        int col;
        logic [7:0] gi;
        logic [7:0] bits;
        msg = (f / MSG_FRAMES) % GREET_MSGS;
        if (ly >= ROW_Y0 && ly < ROW_Y0 + GLYPH_H * SCALE) begin
            trow = 0;
            grow = (ly - ROW_Y0) / SCALE;
        end else if (ly >= ROW_Y1 && ly < ROW_Y1 + GLYPH_H * SCALE) begin
            trow = 1;
            grow = (ly - ROW_Y1) / SCALE;
        end else begin
            return 1'b0;
        end
        if (px < SLOT_X0 || px >= SLOT_X0 + SLOTS * SLOT_PITCH) return 1'b0;
        slot = (px - SLOT_X0) / SLOT_PITCH;
        col  = ((px - SLOT_X0) % SLOT_PITCH) / SCALE;
        gi   = ref_msg[msg * GREET_LEN + trow * SLOTS + slot];
        bits = ref_font[gi * GLYPH_H + grow];
        return bits[7 - col];  // bit 7 is leftmost
    endfunction

    // stripe colour of a text line counted from the nearest load line
    function automatic logic [11:0] stripe_colr(input int ly);
        int base;
        logic [11:0] c;
        if (ly >= STRIPE_B1) begin
            base = STRIPE_B1;
            c    = COLR_B;
        end else if (ly >= STRIPE_A1) begin
            base = STRIPE_A1;
            c    = COLR_A;
        end else if (ly >= STRIPE_B0) begin
            base = STRIPE_B0;
            c    = COLR_B;
        end else begin
            base = STRIPE_A0;
            c    = COLR_A;
        end
        c = c + COLR_STEP * 12'((ly - base) / STRIPE_LINES);
        return c;
    endfunction

    task automatic check_reset(input string when_s);
        assert (vid.hsync === 1'b1 && vid.vsync === 1'b1 && vid.de === 1'b0
                && {vid.r, vid.g, vid.b} === 12'h000)
            else report_word({"reset ", when_s}, 32'h6000, 32'(vid));
    endtask

    task automatic check_pixel(input int f, input int ly, input int px,
                               input logic [11:0] c);
        logic  lit;
        string name;
        lit  = model_lit(f, ly, px);
        name = (ly >= ROW_Y0 && ly < ROW_Y0 + GLYPH_H * SCALE) ? "message" : "text";
        name = $sformatf("%s frame %0d line %0d px %0d", name, f, ly, px);
        assert ((c != 12'h000) == lit) else report_count(name, lit, c != 12'h000);
        if (lit) begin
            assert (c == stripe_colr(ly))
                else report_word({"stripe ", name}, stripe_colr(ly), c);
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        err_cnt = 0;
        $readmemh(GREET_FILE, ref_msg);
        $readmemh(FONT_FILE, ref_font);
        repeat (3) begin
            @(negedge clk_pix);
            check_reset("held");
        end
        rst_n = 1'b1;
        @(negedge clk_pix);
        check_reset("first cycle after");

        prev_hs    = 1'b1;
        prev_vs    = 1'b1;
        prev_de    = 1'b0;
        seen_rise  = 1'b0;
        cyc        = 0;
        x          = 0;
        y          = 0;
        frm        = 0;
        hs_low     = 0;
        since_rise = 0;
        vs_low     = 0;
        de_rise_at = 0;
        hs_fall_at = -1;
        while (frm < RUN_FRAMES && cyc < RUN_LIMIT) begin
            @(negedge clk_pix);
            cyc++;
            rgb = {vid.r, vid.g, vid.b};

            if (!vid.hsync && prev_hs) begin
                if (hs_fall_at >= 0) begin
                    assert (cyc - hs_fall_at == H_TOTAL)
                        else report_count("hsync period", H_TOTAL, cyc - hs_fall_at);
                end
                hs_fall_at = cyc;
                hs_low     = 0;
            end
            if (!vid.hsync) hs_low++;
            if (vid.hsync && !prev_hs) begin
                assert (hs_low == H_SYNC_END - H_SYNC_START + 1)
                    else report_count("hsync width", H_SYNC_END - H_SYNC_START + 1, hs_low);
                since_rise = 0;
                seen_rise  = 1'b1;
            end else begin
                since_rise++;
            end

            if (vid.de && !prev_de) begin
                if (seen_rise) begin
                    assert (since_rise == 48) else report_count("back porch", 48, since_rise);
                end
                de_rise_at = cyc;
                x          = 0;
            end
            if (!vid.de && prev_de) begin
                assert (x == H_RES) else report_count("de width", H_RES, x);
                y++;
            end

            if (vid.de) begin
                // no glyph rows are fetched before the first line after reset
                if (!(frm == 0 && y == 0)) check_pixel(frm, y, x, rgb);
                x++;
            end else begin
                assert (rgb == 12'h000) else report_word("blank colour", 0, rgb);
            end

            if (!vid.vsync && prev_vs) begin
                assert (y == V_RES) else report_count("frame lines", V_RES, y);
                // ten blank lines between the last de line and vsync
                assert (cyc - de_rise_at == 11 * H_TOTAL)
                    else report_count("vsync position", 11 * H_TOTAL, cyc - de_rise_at);
                vs_low = 0;
                frm++;
                y = 0;
            end
            if (!vid.vsync) vs_low++;
            if (vid.vsync && !prev_vs) begin
                assert (vs_low == 2 * H_TOTAL)
                    else report_count("vsync width", 2 * H_TOTAL, vs_low);
            end

            prev_hs = vid.hsync;
            prev_vs = vid.vsync;
            prev_de = vid.de;
        end

        if (frm < RUN_FRAMES) begin
            $display("timeout: only %0d of %0d frames seen", frm, RUN_FRAMES);
            err_cnt++;
        end
        end_run();
    end

endmodule

`default_nettype wire

//--- build.f
rtl/greet_pkg.sv
rtl/display_timing.sv
rtl/text_fetch.sv
rtl/glyph_fetch.sv
rtl/glyph_draw.sv
rtl/colour_mix.sv
rtl/greet_top.sv
tb/tb_clock.sv
tb/greet_tb.sv

//--- rtl/greet.mem
// glyph index per character, 16 per message, row 0 chars then row 1 chars
// 0 space 1 H 2 E 3 L 4 O 5 W 6 R 7 D
0 // msg 0 row 0 " HELLO  "
1
2
3
3
4
0
0
0 // msg 0 row 1 " WORLD  "
5
4
6
3
7
0
0
0 // msg 1 row 0 "  HOLD  "
0
1
4
3
7
0
0
0 // msg 1 row 1 "  HERO  "
0
1
2
6
4
0
0

//--- rtl/font.mem
// one glyph row per line, 8 rows per glyph, bit 7 is the leftmost pixel
00 // space
00
00
00
00
00
00
00
66 // H
66
66
7E
66
66
66
00
7E // E
60
60
7C
60
60
7E
00
60 // L
60
60
60
60
60
7E
00
3C // O
66
66
66
66
66
3C
00
63 // W
63
63
6B
7F
77
63
00
7C // R
66
66
7C
78
6C
66
00
78 // D
6C
66
66
66
6C
78
00
